// ==== common/decode_pkg.sv ====
package decode_pkg;

   // architectural widths
   localparam int XLEN      = 32;
   localparam int NREG_BITS = 5;
   localparam int IMM_BITS  = 16;
   localparam int IDX_BITS  = 26;  // j/jal target index
   localparam int OPC_BITS  = 6;
   localparam int FUNC_BITS = 6;

   localparam logic [NREG_BITS-1:0] REG_RA = 5'd31;  // link register

   // primary opcodes, instr[31:26]
   localparam logic [OPC_BITS-1:0] OP_SPECIAL = 6'h00;
   localparam logic [OPC_BITS-1:0] OP_J       = 6'h02;
   localparam logic [OPC_BITS-1:0] OP_JAL     = 6'h03;
   localparam logic [OPC_BITS-1:0] OP_BEQ     = 6'h04;
   localparam logic [OPC_BITS-1:0] OP_BNE     = 6'h05;
   localparam logic [OPC_BITS-1:0] OP_ADDI    = 6'h08;
   localparam logic [OPC_BITS-1:0] OP_ANDI    = 6'h0c;
   localparam logic [OPC_BITS-1:0] OP_ORI     = 6'h0d;
   localparam logic [OPC_BITS-1:0] OP_LUI     = 6'h0f;
   localparam logic [OPC_BITS-1:0] OP_LW      = 6'h23;
   localparam logic [OPC_BITS-1:0] OP_SW      = 6'h2b;

   // SPECIAL function field, instr[5:0]
   localparam logic [FUNC_BITS-1:0] FN_SLL  = 6'h00;
   localparam logic [FUNC_BITS-1:0] FN_SRL  = 6'h02;
   localparam logic [FUNC_BITS-1:0] FN_SRA  = 6'h03;
   localparam logic [FUNC_BITS-1:0] FN_JR   = 6'h08;
   localparam logic [FUNC_BITS-1:0] FN_JALR = 6'h09;

   typedef enum logic [2:0] {
      ALU_NONE,
      ALU_ADD,
      ALU_AND,
      ALU_OR,
      ALU_LUI,
      ALU_JAL,
      ALU_FUNC   // execute decodes the function field
   } alu_op_t;

   // alu operand a source
   typedef enum logic [1:0] {A_PC, A_RS, A_SHAMT, A_NONE} a_sel_t;

   // alu operand b source
   typedef enum logic {B_RT, B_IMM} b_sel_t;

   typedef enum logic [1:0] {DST_RD, DST_RT, DST_RA} dst_sel_t;

   typedef enum logic [1:0] {EXT_IDX, EXT_SGN, EXT_ZRO, EXT_SHAMT} ext_sel_t;

   typedef enum logic [1:0] {MEM_NONE, MEM_WORD} mem_op_t;

   typedef enum logic {WB_ALU, WB_MEM} wb_src_t;

   typedef struct packed {
      alu_op_t  alu_op;
      a_sel_t   a_sel;
      b_sel_t   b_sel;
      dst_sel_t dst_sel;
   } ex_ctrl_t;

   typedef struct packed {
      mem_op_t rd;
      mem_op_t wr;
   } mem_ctrl_t;

   typedef struct packed {
      logic    wenb;
      wb_src_t src;
   } wb_ctrl_t;

   // consumed inside decode only, never latched
   typedef struct packed {
      logic is_beq;
      logic is_bne;
      logic is_jump;
      logic is_jreg;
   } flow_ctrl_t;

   typedef struct packed {
      logic [XLEN-1:0]      pc;       // pc+4
      logic [XLEN-1:0]      rs_val;
      logic [XLEN-1:0]      rt_val;
      logic [XLEN-1:0]      ext_imm;
      logic [FUNC_BITS-1:0] func;
      logic [NREG_BITS-1:0] rs_num;
      logic [NREG_BITS-1:0] rt_num;
      logic [NREG_BITS-1:0] rd_num;
      ex_ctrl_t             ex;
      mem_ctrl_t            mem;
      wb_ctrl_t             wb;
   } id_ex_t;

endpackage

// ==== rtl/reg_file.sv ====
module reg_file (
   input  logic                           i_clk,
   input  logic                           i_rst,
   input  logic [decode_pkg::NREG_BITS-1:0] i_rs_num,
   input  logic [decode_pkg::NREG_BITS-1:0] i_rt_num,
   input  logic [decode_pkg::NREG_BITS-1:0] i_wr_num,
   input  logic [decode_pkg::XLEN-1:0]      i_wr_data,
   input  logic                           i_wr_enb,
   output logic [decode_pkg::XLEN-1:0]      o_rs_val,
   output logic [decode_pkg::XLEN-1:0]      o_rt_val,
   output logic                           o_equal
);

   import decode_pkg::*;

   localparam int NREGS = 2 ** NREG_BITS;

   logic [XLEN-1:0] regs [NREGS];

   // write at the edge, readers see it next cycle
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wr_enb && (i_wr_num != '0)) begin  // $zero stays zero
         regs[i_wr_num] <= i_wr_data;
      end
   end

   // no bypass from the write port
   always_comb begin
      o_rs_val = regs[i_rs_num];
      o_rt_val = regs[i_rt_num];
   end

   // compare for beq/bne resolved in decode
   assign o_equal = (o_rs_val == o_rt_val);

endmodule

// ==== decode/ctrl_decoder.sv ====
module ctrl_decoder (
   input  logic [decode_pkg::XLEN-1:0] i_instr,
   output decode_pkg::ex_ctrl_t        o_ex,
   output decode_pkg::mem_ctrl_t       o_mem,
   output decode_pkg::wb_ctrl_t        o_wb,
   output decode_pkg::flow_ctrl_t      o_flow,
   output logic [decode_pkg::XLEN-1:0] o_ext_imm
);

   import decode_pkg::*;

   logic [OPC_BITS-1:0]  opcode;
   logic [FUNC_BITS-1:0] func;
   logic                 is_jreg_fn;
   ext_sel_t             ext_sel;

   assign opcode     = i_instr[31:26];
   assign func       = i_instr[FUNC_BITS-1:0];
   assign is_jreg_fn = (func == FN_JR) || (func == FN_JALR);

   always_comb begin
      // inactive defaults, also used for unknown opcodes
      ext_sel        = EXT_SGN;
      o_ex.alu_op    = ALU_NONE;
      o_ex.a_sel     = A_NONE;
      o_ex.b_sel     = B_IMM;
      o_ex.dst_sel   = DST_RD;
      o_mem.rd       = MEM_NONE;
      o_mem.wr       = MEM_NONE;
      o_wb.wenb      = 1'b0;
      o_wb.src       = WB_ALU;
      o_flow         = '0;

      case (opcode)
         OP_SPECIAL: begin
            ext_sel      = EXT_SHAMT;
            o_ex.alu_op  = ALU_FUNC;
            o_ex.b_sel   = B_RT;
            case (func)
               FN_JALR:                  o_ex.a_sel = A_PC;     // link value
               FN_SLL, FN_SRL, FN_SRA:   o_ex.a_sel = A_SHAMT;
               default:                  o_ex.a_sel = A_RS;
            endcase
            o_flow.is_jump = is_jreg_fn;
            o_flow.is_jreg = is_jreg_fn;
            // jr and the nop write nothing
            o_wb.wenb = !((func == FN_JR) || (i_instr == '0));
         end
         OP_J: begin
            ext_sel        = EXT_IDX;
            o_flow.is_jump = 1'b1;
         end
         OP_JAL: begin
            ext_sel        = EXT_IDX;
            o_ex.alu_op    = ALU_JAL;
            o_ex.a_sel     = A_PC;
            o_ex.dst_sel   = DST_RA;   // $ra
            o_wb.wenb      = 1'b1;
            o_flow.is_jump = 1'b1;
         end
         OP_BEQ: begin
            o_flow.is_beq = 1'b1;
         end
         OP_BNE: begin
            o_flow.is_bne = 1'b1;
         end
         OP_ADDI: begin
            o_ex.alu_op  = ALU_ADD;
            o_ex.a_sel   = A_RS;
            o_ex.dst_sel = DST_RT;
            o_wb.wenb    = 1'b1;
         end
         OP_ANDI: begin
            ext_sel      = EXT_ZRO;
            o_ex.alu_op  = ALU_AND;
            o_ex.a_sel   = A_RS;
            o_ex.dst_sel = DST_RT;
            o_wb.wenb    = 1'b1;
         end
         OP_ORI: begin
            ext_sel      = EXT_ZRO;
            o_ex.alu_op  = ALU_OR;
            o_ex.a_sel   = A_RS;
            o_ex.dst_sel = DST_RT;
            o_wb.wenb    = 1'b1;
         end
         OP_LUI: begin
            ext_sel      = EXT_ZRO;
            o_ex.alu_op  = ALU_LUI;   // rs unused
            o_ex.dst_sel = DST_RT;
            o_wb.wenb    = 1'b1;
         end
         OP_LW: begin
            o_ex.alu_op  = ALU_ADD;   // base + offset
            o_ex.a_sel   = A_RS;
            o_ex.dst_sel = DST_RT;
            o_mem.rd     = MEM_WORD;
            o_wb.wenb    = 1'b1;
            o_wb.src     = WB_MEM;
         end
         OP_SW: begin
            o_ex.alu_op  = ALU_ADD;
            o_ex.a_sel   = A_RS;
            o_ex.dst_sel = DST_RT;
            o_mem.wr     = MEM_WORD;
         end
         default: ;
      endcase
   end

   // immediate extension
   always_comb begin
      case (ext_sel)
         EXT_IDX:   o_ext_imm = {{(XLEN-IDX_BITS){1'b0}}, i_instr[IDX_BITS-1:0]};
         EXT_ZRO:   o_ext_imm = {{(XLEN-IMM_BITS){1'b0}}, i_instr[IMM_BITS-1:0]};
         EXT_SHAMT: o_ext_imm = {{(XLEN-NREG_BITS){1'b0}}, i_instr[10:6]};
         default:   o_ext_imm = {{(XLEN-IMM_BITS){i_instr[IMM_BITS-1]}},
                                 i_instr[IMM_BITS-1:0]};
      endcase
   end

endmodule

// ==== decode/branch_unit.sv ====
module branch_unit (
   input  logic [decode_pkg::XLEN-1:0] i_pc,
   input  logic [decode_pkg::XLEN-1:0] i_ext_imm,
   input  logic [decode_pkg::XLEN-1:0] i_rs_val,
   input  logic                        i_equal,
   input  decode_pkg::flow_ctrl_t      i_flow,
   output logic [decode_pkg::XLEN-1:0] o_brh_addr,
   output logic [decode_pkg::XLEN-1:0] o_jmp_addr,
   output logic                        o_pc_beq,
   output logic                        o_pc_src,
   output logic                        o_flush,
   output logic                        o_is_branch,
   output logic                        o_is_jreg
);

   import decode_pkg::*;

   localparam int SEG_BITS = XLEN - IDX_BITS - 2;  // pc bits kept by j/jal

   logic taken;

   // pc+4 plus word offset, wraps like the real adder
   assign o_brh_addr = i_pc + {i_ext_imm[XLEN-3:0], 2'b00};

   // jr/jalr take rs, j/jal stay in the current 256MB segment
   always_comb begin
      if (i_flow.is_jreg) begin
         o_jmp_addr = i_rs_val;
      end else begin
         o_jmp_addr = {i_pc[XLEN-1 -: SEG_BITS], i_ext_imm[IDX_BITS-1:0], 2'b00};
      end
   end

   assign taken = (i_flow.is_beq & i_equal) | (i_flow.is_bne & ~i_equal);

   assign o_pc_beq = taken;
   assign o_pc_src = i_flow.is_jump;
   assign o_flush  = taken | i_flow.is_jump;  // kill the fetched slot

   // hazard unit needs these even when not taken
   assign o_is_branch = i_flow.is_beq | i_flow.is_bne;
   assign o_is_jreg   = i_flow.is_jreg;

endmodule

// ==== decode/id_ex_latch.sv ====
module id_ex_latch (
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_enb,
   input  logic               i_bubble,
   input  decode_pkg::id_ex_t i_d,
   output decode_pkg::id_ex_t o_q
);

   import decode_pkg::*;

   id_ex_t d_next;

   // bubble keeps the data fields, only controls go inactive
   always_comb begin
      d_next = i_d;
      if (i_bubble) begin
         d_next.ex  = '0;
         d_next.mem = '0;
         d_next.wb  = '0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_q <= '0;
      end else if (i_enb) begin  // low enable is the stall
         o_q <= d_next;
      end
   end

endmodule

// ==== decode/decode_stage.sv ====
module decode_stage (
   input  logic                             i_clk,
   input  logic                             i_rst,
   input  logic [decode_pkg::XLEN-1:0]      i_pc,
   input  logic [decode_pkg::XLEN-1:0]      i_instr,
   input  logic [decode_pkg::XLEN-1:0]      i_wb_data,
   input  logic [decode_pkg::NREG_BITS-1:0] i_wb_dst,
   input  logic                             i_wb_wenb,
   input  logic                             i_enb,
   input  logic                             i_bubble,
   output decode_pkg::id_ex_t               o_id_ex,
   output logic [decode_pkg::XLEN-1:0]      o_brh_addr,
   output logic [decode_pkg::XLEN-1:0]      o_jmp_addr,
   output logic                             o_pc_beq,
   output logic                             o_pc_src,
   output logic                             o_flush,
   output logic                             o_is_branch,
   output logic                             o_is_jreg
);

   import decode_pkg::*;

   logic [XLEN-1:0] rs_val;
   logic [XLEN-1:0] rt_val;
   logic [XLEN-1:0] ext_imm;
   logic            equal;
   ex_ctrl_t        ex_ctrl;
   mem_ctrl_t       mem_ctrl;
   wb_ctrl_t        wb_ctrl;
   flow_ctrl_t      flow_ctrl;
   id_ex_t          id_ex_d;

   reg_file u_reg_file (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_rs_num  (i_instr[25:21]),
      .i_rt_num  (i_instr[20:16]),
      .i_wr_num  (i_wb_dst),
      .i_wr_data (i_wb_data),
      .i_wr_enb  (i_wb_wenb),
      .o_rs_val  (rs_val),
      .o_rt_val  (rt_val),
      .o_equal   (equal)
   );

   ctrl_decoder u_ctrl_decoder (
      .i_instr   (i_instr),
      .o_ex      (ex_ctrl),
      .o_mem     (mem_ctrl),
      .o_wb      (wb_ctrl),
      .o_flow    (flow_ctrl),
      .o_ext_imm (ext_imm)
   );

   branch_unit u_branch_unit (
      .i_pc        (i_pc),
      .i_ext_imm   (ext_imm),
      .i_rs_val    (rs_val),
      .i_equal     (equal),
      .i_flow      (flow_ctrl),
      .o_brh_addr  (o_brh_addr),
      .o_jmp_addr  (o_jmp_addr),
      .o_pc_beq    (o_pc_beq),
      .o_pc_src    (o_pc_src),
      .o_flush     (o_flush),
      .o_is_branch (o_is_branch),
      .o_is_jreg   (o_is_jreg)
   );

   // bundle for execute, register numbers straight from the fields
   always_comb begin
      id_ex_d.pc      = i_pc;
      id_ex_d.rs_val  = rs_val;
      id_ex_d.rt_val  = rt_val;
      id_ex_d.ext_imm = ext_imm;
      id_ex_d.func    = i_instr[FUNC_BITS-1:0];
      id_ex_d.rs_num  = i_instr[25:21];
      id_ex_d.rt_num  = i_instr[20:16];
      id_ex_d.rd_num  = i_instr[15:11];
      id_ex_d.ex      = ex_ctrl;
      id_ex_d.mem     = mem_ctrl;
      id_ex_d.wb      = wb_ctrl;
   end

   id_ex_latch u_id_ex_latch (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_enb    (i_enb),
      .i_bubble (i_bubble),
      .i_d      (id_ex_d),
      .o_q      (o_id_ex)
   );

endmodule

// ==== verif/tb_decode_stage.sv ====
module tb_decode_stage;

   import decode_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int DRIVE_DLY  = 2;
   localparam int NUM_TESTS  = 6;

   logic                 i_clk;
   logic                 i_rst;
   logic [XLEN-1:0]      i_pc;
   logic [XLEN-1:0]      i_instr;
   logic [XLEN-1:0]      i_wb_data;
   logic [NREG_BITS-1:0] i_wb_dst;
   logic                 i_wb_wenb;
   logic                 i_enb;
   logic                 i_bubble;
   id_ex_t               id_ex;
   logic [XLEN-1:0]      brh_addr;
   logic [XLEN-1:0]      jmp_addr;
   logic                 pc_beq;
   logic                 pc_src;
   logic                 flush;
   logic                 is_branch;
   logic                 is_jreg;

   int              seed = 33;
   int              errors = 0;
   int              checks = 0;
   int              test_no = 0;
   int              test_err = 0;
   logic [XLEN-1:0] ref_regs [32];  // expected register contents

   logic [OPC_BITS-1:0]  imm_ops   [4] = '{OP_ADDI, OP_ANDI, OP_ORI, OP_LUI};
   alu_op_t              imm_alus  [4] = '{ALU_ADD, ALU_AND, ALU_OR, ALU_LUI};
   logic [FUNC_BITS-1:0] shift_fns [3] = '{FN_SLL, FN_SRL, FN_SRA};

   decode_stage DUT (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_pc        (i_pc),
      .i_instr     (i_instr),
      .i_wb_data   (i_wb_data),
      .i_wb_dst    (i_wb_dst),
      .i_wb_wenb   (i_wb_wenb),
      .i_enb       (i_enb),
      .i_bubble    (i_bubble),
      .o_id_ex     (id_ex),
      .o_brh_addr  (brh_addr),
      .o_jmp_addr  (jmp_addr),
      .o_pc_beq    (pc_beq),
      .o_pc_src    (pc_src),
      .o_flush     (flush),
      .o_is_branch (is_branch),
      .o_is_jreg   (is_jreg)
   );

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
   end

   function automatic logic [31:0] rand32();
      return $random(seed);
   endfunction

   function automatic logic [XLEN-1:0] enc_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                             logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [XLEN-1:0] enc_r(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                             logic [4:0] sa, logic [5:0] fn);
      return {OP_SPECIAL, rs, rt, rd, sa, fn};
   endfunction

   function automatic logic [XLEN-1:0] sext16(logic [15:0] v);
      return {{16{v[15]}}, v};
   endfunction

   task automatic check_eq(input string name, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] want);
      checks++;
      assert (got === want)
      else begin
         $display("FAIL %s got %h exp %h", name, got, want);
         errors++;
      end
   endtask

   task automatic check_bundle(input id_ex_t got, input id_ex_t want);
      checks++;
      assert (got === want)
      else begin
         $display("FAIL o_id_ex got %h exp %h", got, want);
         errors++;
      end
   endtask

   task automatic check_jump(input logic [XLEN-1:0] want_addr);
      check_eq("o_pc_src", pc_src, 1'b1);
      check_eq("o_flush", flush, 1'b1);
      check_eq("o_pc_beq", pc_beq, 1'b0);
      check_eq("o_is_branch", is_branch, 1'b0);
      check_eq("o_jmp_addr", jmp_addr, want_addr);
   endtask

   task automatic advance();
      @(posedge i_clk);
      #DRIVE_DLY;
   endtask

   // drive one instruction, return where the decode outputs are settled
   task automatic present(input logic [XLEN-1:0] instr, input logic [XLEN-1:0] pc);
      advance();
      i_instr = instr;
      i_pc    = pc;
      @(negedge i_clk);
   endtask

   task automatic write_reg(input logic [4:0] num, input logic [XLEN-1:0] val);
      advance();
      i_wb_dst  = num;
      i_wb_data = val;
      i_wb_wenb = 1'b1;
      advance();
      i_wb_wenb = 1'b0;
      ref_regs[num] = (num == 5'd0) ? '0 : val;  // $zero ignores writes
   endtask

   task automatic begin_test();
      test_err = errors;
   endtask

   task automatic finish_test(input string name);
      test_no++;
      if (errors == test_err) begin
         $display("test %0d %s: ok", test_no, name);
      end else begin
         $display("test %0d %s: %0d errors", test_no, name, errors - test_err);
      end
   endtask

   initial begin
      #(NUM_TESTS * 200 * CLK_PERIOD);
      $display("watchdog expired before the tests completed");
      $display("Test failed");
      $finish;
   end

   initial begin
      logic [4:0]      rs;
      logic [4:0]      rt;
      logic [4:0]      sa;
      logic [15:0]     imm;
      logic [25:0]     idx;
      logic [5:0]      op;
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] val;
      logic            taken;
      id_ex_t          held;

      i_rst     = 1'b1;
      i_pc      = '0;
      i_instr   = '0;
      i_wb_data = '0;
      i_wb_dst  = '0;
      i_wb_wenb = 1'b0;
      i_enb     = 1'b1;
      i_bubble  = 1'b0;
      for (int r = 0; r < 32; r++) begin
         ref_regs[r] = '0;
      end

      begin_test();
      repeat (16) @(posedge i_clk);
      #DRIVE_DLY;
      check_bundle(id_ex, '0);
      check_eq("o_flush", flush, 1'b0);
      check_eq("o_pc_src", pc_src, 1'b0);
      check_eq("o_pc_beq", pc_beq, 1'b0);
      i_rst = 1'b0;
      finish_test("reset");

      begin_test();
      for (int r = 0; r < 9; r++) begin
         write_reg(5'(r), rand32());  // r0 included
      end
      for (int k = 0; k < 4; k++) begin
         rs  = 5'd1 + 5'(rand32() & 7);
         rt  = 5'd1 + 5'(rand32() & 7);
         imm = 16'h8000 | 16'(rand32());  // top bit set tells sign from zero extension
         present(enc_i(imm_ops[k], rs, rt, imm), rand32());
         advance();
         check_eq("rs_val", id_ex.rs_val, ref_regs[rs]);
         check_eq("rt_val", id_ex.rt_val, ref_regs[rt]);
         check_eq("rs_num", id_ex.rs_num, rs);
         check_eq("rt_num", id_ex.rt_num, rt);
         check_eq("ext_imm", id_ex.ext_imm,
                  (imm_ops[k] == OP_ADDI) ? sext16(imm) : {16'h0, imm});
         check_eq("alu_op", id_ex.ex.alu_op, imm_alus[k]);
         check_eq("dst_sel", id_ex.ex.dst_sel, DST_RT);
         check_eq("wb.wenb", id_ex.wb.wenb, 1'b1);
      end
      present(enc_i(OP_ADDI, 5'd0, 5'd0, 16'h0001), rand32());
      advance();
      check_eq("rs_val", id_ex.rs_val, '0);
      check_eq("rt_val", id_ex.rt_val, '0);
      finish_test("imm_ops");

      begin_test();
      imm = 16'h8000 | 16'(rand32());  // negative offset
      present(enc_i(OP_LW, 5'd1, 5'd2, imm), rand32());
      advance();
      check_eq("mem.rd", id_ex.mem.rd, MEM_WORD);
      check_eq("mem.wr", id_ex.mem.wr, MEM_NONE);
      check_eq("wb", id_ex.wb, {1'b1, WB_MEM});
      check_eq("alu_op", id_ex.ex.alu_op, ALU_ADD);
      check_eq("ext_imm", id_ex.ext_imm, sext16(imm));
      imm = 16'h8000 | 16'(rand32());
      present(enc_i(OP_SW, 5'd3, 5'd4, imm), rand32());
      advance();
      check_eq("mem.wr", id_ex.mem.wr, MEM_WORD);
      check_eq("mem.rd", id_ex.mem.rd, MEM_NONE);
      check_eq("wb.wenb", id_ex.wb.wenb, 1'b0);
      check_eq("alu_op", id_ex.ex.alu_op, ALU_ADD);
      check_eq("ext_imm", id_ex.ext_imm, sext16(imm));
      finish_test("load_store");

      begin_test();
      val = rand32();
      write_reg(5'd9, val);
      write_reg(5'd10, val);
      write_reg(5'd11, val ^ 32'h1);  // guaranteed unequal pair
      for (int k = 0; k < 4; k++) begin
         op  = (k < 2) ? OP_BEQ : OP_BNE;
         rt  = (k % 2 == 1) ? 5'd11 : 5'd10;
         imm = (k % 2 == 1) ? 16'hfff0 : 16'(rand32());
         pc  = rand32();
         present(enc_i(op, 5'd9, rt, imm), pc);
         taken = ((op == OP_BEQ) == (ref_regs[9] == ref_regs[rt]));
         check_eq("o_pc_beq", pc_beq, taken);
         check_eq("o_flush", flush, taken);
         check_eq("o_pc_src", pc_src, 1'b0);
         check_eq("o_is_branch", is_branch, 1'b1);
         check_eq("o_is_jreg", is_jreg, 1'b0);
         check_eq("o_brh_addr", brh_addr, pc + (sext16(imm) << 2));
      end
      finish_test("branches");

      begin_test();
      idx = 26'(rand32());
      pc  = rand32();
      present({OP_J, idx}, pc);
      check_jump({pc[31:28], idx, 2'b00});
      idx = 26'(rand32());
      pc  = rand32();
      present({OP_JAL, idx}, pc);
      check_jump({pc[31:28], idx, 2'b00});
      advance();
      check_eq("dst_sel", id_ex.ex.dst_sel, DST_RA);
      check_eq("a_sel", id_ex.ex.a_sel, A_PC);
      present(enc_r(5'd5, 5'd0, 5'd0, 5'd0, FN_JR), rand32());
      check_jump(ref_regs[5]);
      check_eq("o_is_jreg", is_jreg, 1'b1);
      advance();
      check_eq("wb.wenb", id_ex.wb.wenb, 1'b0);
      present(enc_r(5'd6, 5'd0, 5'd31, 5'd0, FN_JALR), rand32());
      check_jump(ref_regs[6]);
      check_eq("o_is_jreg", is_jreg, 1'b1);
      advance();
      check_eq("wb.wenb", id_ex.wb.wenb, 1'b1);
      check_eq("a_sel", id_ex.ex.a_sel, A_PC);
      for (int k = 0; k < 3; k++) begin
         sa = 5'(rand32());
         present(enc_r(5'd0, 5'd7, 5'd8, sa, shift_fns[k]), rand32());
         advance();
         check_eq("a_sel", id_ex.ex.a_sel, A_SHAMT);
         check_eq("ext_imm", id_ex.ext_imm, {27'h0, sa});
         check_eq("rd_num", id_ex.rd_num, 5'd8);
         check_eq("func", id_ex.func, shift_fns[k]);
      end
      finish_test("jumps_shifts");

      begin_test();
      present(enc_i(OP_ADDI, 5'd2, 5'd3, 16'(rand32())), rand32());
      advance();
      held  = id_ex;
      i_enb = 1'b0;  // stall
      present(enc_i(OP_ORI, 5'd4, 5'd5, 16'(rand32())), rand32());
      advance();
      advance();
      check_bundle(id_ex, held);
      i_enb    = 1'b1;
      i_bubble = 1'b1;
      pc       = rand32();
      present(enc_i(OP_ORI, 5'd4, 5'd5, 16'(rand32())), pc);
      advance();
      check_eq("ex", id_ex.ex, '0);
      check_eq("mem", id_ex.mem, '0);
      check_eq("wb", id_ex.wb, '0);
      check_eq("pc", id_ex.pc, pc);
      check_eq("rs_val", id_ex.rs_val, ref_regs[4]);
      i_bubble = 1'b0;
      finish_test("stall_bubble");

      $display("tests %0d, checks %0d, errors %0d", test_no, checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
common/decode_pkg.sv
rtl/reg_file.sv
decode/ctrl_decoder.sv
decode/branch_unit.sv
decode/id_ex_latch.sv
decode/decode_stage.sv
verif/tb_decode_stage.sv
